// File: src/clic_pkg.sv
package clic_pkg;

  // sizes of the block.
  localparam int clic_num_int = 16;
  localparam int clic_num_trig = 4;
  localparam int clic_intctl_bits = 4;
  localparam int clic_trig_idx_bits = $clog2(clic_num_trig);

  localparam int clic_arch_version = 0;
  localparam int clic_impl_version = 0;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [clic_num_int-1:0] int_vec_t;
  typedef logic [$clog2(clic_num_int)-1:0] int_idx_t;
  typedef logic [11:0] int_id_t;
  typedef logic [7:0] ctl_t;
  typedef logic [3:0] nlbits_t;

  // register map, byte addresses.
  localparam addr_t clic_cfg_addr = 32'd0;
  localparam addr_t clic_info_addr = 32'd4;
  localparam addr_t clic_trig_base = 32'd64;
  localparam addr_t clic_int_base = 32'd4096;
  localparam addr_t clic_trig_end = clic_trig_base + addr_t'(4 * clic_num_trig);
  localparam addr_t clic_int_end = clic_int_base + addr_t'(4 * clic_num_int);

  // read-only information word.
  localparam data_t clic_info_word = {
    1'b0,
    6'(clic_num_trig),
    4'(clic_intctl_bits),
    4'(clic_arch_version),
    4'(clic_impl_version),
    13'(clic_num_int)
  };

  // field positions of the per-interrupt word.
  localparam int clic_ip_bit = 0;
  localparam int clic_ie_bit = 8;
  localparam int clic_shv_bit = 16;
  localparam int clic_trig_lsb = 17;
  localparam int clic_mode_lsb = 22;
  localparam int clic_ctl_lsb = 24;

  // unimplemented low bits of the control byte.
  localparam logic [7-clic_intctl_bits:0] clic_ctl_fill = '1;

endpackage

// File: src/clic_regs.sv
`timescale 1ns/10ps

module clic_regs (
  input  logic                clock,
  input  logic                reset,
  input  logic                valid,
  input  clic_pkg::addr_t     addr,
  input  clic_pkg::data_t     wdata,
  input  clic_pkg::strb_t     wstrb,
  input  clic_pkg::int_vec_t  pending,
  output clic_pkg::data_t     rdata,
  output logic                ready,
  output logic                ip_write,
  output clic_pkg::int_idx_t  ip_index,
  output logic                ip_value,
  output clic_pkg::int_vec_t  edge_mode,
  output clic_pkg::int_vec_t  edge_falling,
  output clic_pkg::int_vec_t  enable,
  output clic_pkg::ctl_t      int_ctl [clic_pkg::clic_num_int],
  output clic_pkg::nlbits_t   nlbits
);
  import clic_pkg::*;

  logic is_write;
  logic in_cfg;
  logic in_info;
  logic in_trig;
  logic in_int;

  int_idx_t int_idx;
  logic [clic_trig_idx_bits-1:0] trig_idx;

  data_t trig_word [clic_num_trig];
  int_vec_t enable_q;
  int_vec_t int_shv;
  logic [1:0] int_trig [clic_num_int];
  logic [1:0] int_mode [clic_num_int];
  logic [clic_intctl_bits-1:0] ctl_hi [clic_num_int];

  data_t read_word;

  assign is_write = |wstrb;

  // region decode.
  assign in_cfg = (addr[31:2] == clic_cfg_addr[31:2]);
  assign in_info = (addr[31:2] == clic_info_addr[31:2]);
  assign in_trig = (addr >= clic_trig_base) && (addr < clic_trig_end);
  assign in_int = (addr >= clic_int_base) && (addr < clic_int_end);

  assign int_idx = addr[$bits(int_idx_t)+1:2];
  assign trig_idx = addr[clic_trig_idx_bits+1:2];

  // software pending writes only reach edge-mode interrupts.
  assign ip_write = valid && in_int && wstrb[0] && edge_mode[int_idx];
  assign ip_index = int_idx;
  assign ip_value = wdata[clic_ip_bit];

  assign enable = enable_q;

  always_comb begin
    for (int i = 0; i < clic_num_int; i++) begin
      edge_mode[i] = int_trig[i][0];
      edge_falling[i] = int_trig[i][1]; // value 2 stays level.
      int_ctl[i] = {ctl_hi[i], clic_ctl_fill};
    end
  end

  always_comb begin
    read_word = '0;
    if (in_cfg) begin
      read_word[4:1] = nlbits;
    end else if (in_info) begin
      read_word = clic_info_word;
    end else if (in_trig) begin
      read_word = trig_word[trig_idx];
    end else if (in_int) begin
      read_word[clic_ip_bit] = pending[int_idx];
      read_word[clic_ie_bit] = enable_q[int_idx];
      read_word[clic_shv_bit] = int_shv[int_idx];
      read_word[clic_trig_lsb +: 2] = int_trig[int_idx];
      read_word[clic_mode_lsb +: 2] = int_mode[int_idx];
      read_word[clic_ctl_lsb +: 8] = int_ctl[int_idx];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      nlbits <= '0;
      enable_q <= '0;
      int_shv <= '0;
      for (int i = 0; i < clic_num_trig; i++) begin
        trig_word[i] <= '0;
      end
      for (int i = 0; i < clic_num_int; i++) begin
        int_trig[i] <= '0;
        int_mode[i] <= '0;
        ctl_hi[i] <= '1;
      end
    end else if (valid && is_write) begin
      if (in_cfg && wstrb[0]) begin
        nlbits <= wdata[4:1];
      end
      if (in_trig) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            trig_word[trig_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
      if (in_int) begin
        if (wstrb[1]) begin
          enable_q[int_idx] <= wdata[clic_ie_bit];
        end
        if (wstrb[2]) begin
          int_shv[int_idx] <= wdata[clic_shv_bit];
          int_trig[int_idx] <= wdata[clic_trig_lsb +: 2];
          int_mode[int_idx] <= wdata[clic_mode_lsb +: 2];
        end
        if (wstrb[3]) begin
          ctl_hi[int_idx] <= wdata[31 -: clic_intctl_bits]; // top bits only.
        end
      end
    end
  end

  // every strobe is answered, unmapped ones read zero.
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid;
    end
  end

  always_ff @(posedge clock) begin
    rdata <= (valid && !is_write) ? read_word : '0;
  end

  ready_follows_valid: assert property (
    @(posedge clock) disable iff (reset)
    !$past(reset) |-> (ready == $past(valid))
  ) else $error("ready does not follow valid");

endmodule

// File: src/clic_pending.sv
`timescale 1ns/10ps

module clic_pending (
  input  logic                clock,
  input  logic                reset,
  input  clic_pkg::int_vec_t  lines,
  input  logic                ip_write,
  input  clic_pkg::int_idx_t  ip_index,
  input  logic                ip_value,
  input  clic_pkg::int_vec_t  edge_mode,
  input  clic_pkg::int_vec_t  edge_falling,
  output clic_pkg::int_vec_t  pending
);
  import clic_pkg::*;

  int_vec_t line_q;
  int_vec_t rise;
  int_vec_t fall;
  int_vec_t edge_hit;

  assign rise = lines & ~line_q;
  assign fall = ~lines & line_q;

  // select the configured edge per interrupt.
  assign edge_hit = (edge_falling & fall) | (~edge_falling & rise);

  always_ff @(posedge clock) begin
    if (reset) begin
      line_q <= '0;
    end else begin
      line_q <= lines;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else begin
      for (int i = 0; i < clic_num_int; i++) begin
        if (!edge_mode[i]) begin
          pending[i] <= lines[i];
        end else if (edge_hit[i]) begin
          pending[i] <= 1'b1; // edge beats a software clear.
        end else if (ip_write && (ip_index == int_idx_t'(i))) begin
          pending[i] <= ip_value;
        end
      end
    end
  end

  for (genvar g = 0; g < clic_num_int; g++) begin : g_level_check
    level_tracks_line: assert property (
      @(posedge clock) disable iff (reset)
      (!$past(reset) && !$past(edge_mode[g])) |-> (pending[g] == $past(lines[g]))
    ) else $error("level pending %0d does not track its line", g);
  end

endmodule

// File: src/clic_arbiter.sv
`timescale 1ns/10ps

module clic_arbiter (
  input  logic                clock,
  input  logic                reset,
  input  clic_pkg::int_vec_t  pending,
  input  clic_pkg::int_vec_t  enable,
  input  clic_pkg::ctl_t      int_ctl [clic_pkg::clic_num_int],
  input  clic_pkg::nlbits_t   nlbits,
  output logic                meip,
  output clic_pkg::int_id_t   meid
);
  import clic_pkg::*;

  nlbits_t nl_used;
  ctl_t level [clic_num_int];
  ctl_t prio [clic_num_int];

  int_vec_t candidate;

  logic best_found;
  int_idx_t best_idx;
  ctl_t best_level;
  ctl_t best_prio;

  // level bits cannot exceed the implemented control bits.
  assign nl_used = (nlbits > nlbits_t'(clic_intctl_bits)) ?
                   nlbits_t'(clic_intctl_bits) : nlbits;

  assign candidate = pending & enable;

  always_comb begin
    for (int i = 0; i < clic_num_int; i++) begin
      level[i] = int_ctl[i] | (8'hff >> nl_used);
      prio[i] = (int_ctl[i] << nl_used) | ~(8'hff << nl_used);
    end
  end

  // strict compare keeps the lowest number on a tie.
  always_comb begin
    best_found = 1'b0;
    best_idx = '0;
    best_level = '0;
    best_prio = '0;
    for (int i = 1; i < clic_num_int; i++) begin
      if (candidate[i]) begin
        if (!best_found ||
            (level[i] > best_level) ||
            ((level[i] == best_level) && (prio[i] > best_prio))) begin
          best_found = 1'b1;
          best_idx = int_idx_t'(i);
          best_level = level[i];
          best_prio = prio[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      meip <= 1'b0;
      meid <= '0;
    end else begin
      meip <= best_found;
      meid <= best_found ? int_id_t'(best_idx) : '0;
    end
  end

  winner_is_live: assert property (
    @(posedge clock) disable iff (reset)
    meip |-> ((meid != '0) &&
              ((($past(candidate) >> meid[$bits(int_idx_t)-1:0]) & int_vec_t'(1)) != '0))
  ) else $error("meid %0d is not a pending, enabled interrupt", meid);

endmodule

// File: src/clic_top.sv
`timescale 1ns/10ps

module clic_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                clic_valid,
  input  clic_pkg::addr_t     clic_addr,
  input  clic_pkg::data_t     clic_wdata,
  input  clic_pkg::strb_t     clic_wstrb,
  input  clic_pkg::int_vec_t  clic_irpt,
  output clic_pkg::data_t     clic_rdata,
  output logic                clic_ready,
  output logic                clic_meip,
  output clic_pkg::int_id_t   clic_meid
);
  import clic_pkg::*;

  logic ip_write;
  int_idx_t ip_index;
  logic ip_value;
  int_vec_t edge_mode;
  int_vec_t edge_falling;
  int_vec_t pending;
  int_vec_t enable;
  ctl_t int_ctl [clic_num_int];
  nlbits_t nlbits;

  clic_regs clic_regs_inst (
    .clock        (clock),
    .reset        (reset),
    .valid        (clic_valid),
    .addr         (clic_addr),
    .wdata        (clic_wdata),
    .wstrb        (clic_wstrb),
    .pending      (pending),
    .rdata        (clic_rdata),
    .ready        (clic_ready),
    .ip_write     (ip_write),
    .ip_index     (ip_index),
    .ip_value     (ip_value),
    .edge_mode    (edge_mode),
    .edge_falling (edge_falling),
    .enable       (enable),
    .int_ctl      (int_ctl),
    .nlbits       (nlbits)
  );

  clic_pending clic_pending_inst (
    .clock        (clock),
    .reset        (reset),
    .lines        (clic_irpt),
    .ip_write     (ip_write),
    .ip_index     (ip_index),
    .ip_value     (ip_value),
    .edge_mode    (edge_mode),
    .edge_falling (edge_falling),
    .pending      (pending)
  );

  clic_arbiter clic_arbiter_inst (
    .clock   (clock),
    .reset   (reset),
    .pending (pending),
    .enable  (enable),
    .int_ctl (int_ctl),
    .nlbits  (nlbits),
    .meip    (clic_meip),
    .meid    (clic_meid)
  );

endmodule

// File: bench/clic_tb.sv
`timescale 1ns/10ps

module clic_tb;
  import clic_pkg::*;

  localparam int bus_limit = 8; // cycles allowed for ready.

  logic clock = 1'b0;
  logic reset;
  logic clic_valid;
  addr_t clic_addr;
  data_t clic_wdata;
  strb_t clic_wstrb;
  int_vec_t clic_irpt;
  data_t clic_rdata;
  logic clic_ready;
  logic clic_meip;
  int_id_t clic_meid;

  // shadow of the register state.
  int_vec_t sh_enable;
  int_vec_t sh_shv;
  int_vec_t sh_pending;
  logic [1:0] sh_trig [clic_num_int];
  logic [1:0] sh_mode [clic_num_int];
  logic [3:0] sh_ctl_hi [clic_num_int];
  data_t sh_trig_word [clic_num_trig];
  nlbits_t sh_nlbits;
  int_vec_t lines_now;

  integer seed = 69;
  int checks = 0;
  int errors = 0;
  int first_check = 0;
  int first_error = 0;
  logic [31:0] rnd;
  data_t d;
  data_t r;
  addr_t a;
  strb_t s;
  int waited;
  int_vec_t next_lines;
  addr_t holes [5] = '{32'd8, 32'd60, 32'd80, 32'd4160, 32'h8000_0000};
  addr_t burst [5] = '{32'd4, 32'd4108, 32'd4108, 32'd0, 32'd200};
  strb_t burst_strb [5] = '{4'h0, 4'hf, 4'h0, 4'h0, 4'h0};

  clic_top clic_top_inst (
    .clock      (clock),
    .reset      (reset),
    .clic_valid (clic_valid),
    .clic_addr  (clic_addr),
    .clic_wdata (clic_wdata),
    .clic_wstrb (clic_wstrb),
    .clic_irpt  (clic_irpt),
    .clic_rdata (clic_rdata),
    .clic_ready (clic_ready),
    .clic_meip  (clic_meip),
    .clic_meid  (clic_meid)
  );

  always #10 clock = ~clock;

  function automatic addr_t int_addr(input int i);
    return 32'd4096 + 32'(4 * i);
  endfunction

  function automatic data_t int_word(input logic ip, input logic en, input logic [1:0] trig,
                                     input logic [3:0] ctl);
    data_t w;
    w = '0;
    w[0] = ip;
    w[8] = en;
    w[18:17] = trig;
    w[31:28] = ctl;
    return w;
  endfunction

  function automatic data_t expected_read(input addr_t ad);
    data_t w;
    int i;
    w = '0;
    if (ad[31:2] == 30'd0) begin
      w[4:1] = sh_nlbits;
    end else if (ad[31:2] == 30'd1) begin
      w = (32'd4 << 25) | (32'd4 << 21) | 32'd16; // 4 triggers, 4 ctl bits, 16 lines.
    end else if (ad >= 32'd64 && ad < 32'd80) begin
      w = sh_trig_word[ad[3:2]];
    end else if (ad >= 32'd4096 && ad < 32'd4160) begin
      i = int'(ad[5:2]);
      w[0] = sh_trig[i][0] ? sh_pending[i] : lines_now[i];
      w[8] = sh_enable[i];
      w[16] = sh_shv[i];
      w[18:17] = sh_trig[i];
      w[23:22] = sh_mode[i];
      w[31:24] = {sh_ctl_hi[i], 4'hf};
    end
    return w;
  endfunction

  function automatic void model_write(input addr_t ad, input data_t wd, input strb_t st);
    int i;
    if (ad[31:2] == 30'd0 && st[0]) begin
      sh_nlbits = wd[4:1];
    end else if (ad >= 32'd64 && ad < 32'd80) begin
      for (int b = 0; b < 4; b++) begin
        if (st[b]) sh_trig_word[ad[3:2]][8*b +: 8] = wd[8*b +: 8];
      end
    end else if (ad >= 32'd4096 && ad < 32'd4160) begin
      i = int'(ad[5:2]);
      if (!sh_trig[i][0]) begin
        sh_pending[i] = lines_now[i]; // level pending holds the line.
      end else if (st[0]) begin
        sh_pending[i] = wd[0];
      end
      if (st[1]) sh_enable[i] = wd[8];
      if (st[2]) begin
        sh_shv[i] = wd[16];
        sh_trig[i] = wd[18:17];
        sh_mode[i] = wd[23:22];
      end
      if (st[3]) sh_ctl_hi[i] = wd[31:28];
    end
  endfunction

  // expected meid, 0 when nothing qualifies.
  function automatic int_id_t best_interrupt();
    int nl;
    logic [7:0] ctl;
    logic [7:0] lvl;
    logic [7:0] prio;
    logic [7:0] best_lvl;
    logic [7:0] best_prio;
    logic found;
    int_id_t best;
    nl = (sh_nlbits > 4'd4) ? 4 : int'(sh_nlbits);
    found = 1'b0;
    best = '0;
    best_lvl = '0;
    best_prio = '0;
    for (int i = 1; i < clic_num_int; i++) begin
      ctl = {sh_ctl_hi[i], 4'hf};
      lvl = ctl;
      prio = ctl << nl;
      for (int b = 0; b < 8; b++) begin
        if (b < 8 - nl) lvl[b] = 1'b1;
        if (b < nl) prio[b] = 1'b1;
      end
      if (sh_enable[i] && (sh_trig[i][0] ? sh_pending[i] : lines_now[i])) begin
        if (!found || lvl > best_lvl || (lvl == best_lvl && prio > best_prio)) begin
          found = 1'b1;
          best = int_id_t'(i);
          best_lvl = lvl;
          best_prio = prio;
        end
      end
    end
    return best;
  endfunction

  task automatic compare(input string test, input data_t expected, input data_t actual);
    checks++;
    assert (expected == actual) else begin
      $display("mismatch %s expected %h actual %h", test, expected, actual);
      errors++;
    end
  endtask

  task automatic bus_access(input addr_t ad, input data_t wd, input strb_t st,
                            output data_t rd, output int lat);
    @(posedge clock);
    clic_valid <= 1'b1;
    clic_addr <= ad;
    clic_wdata <= wd;
    clic_wstrb <= st;
    @(posedge clock);
    clic_valid <= 1'b0;
    clic_wstrb <= '0;
    lat = 0;
    @(negedge clock);
    while (!clic_ready && lat < bus_limit) begin
      @(negedge clock);
      lat++;
    end
    checks++;
    assert (clic_ready) else begin
      $display("bus timeout, no ready within %0d cycles at address %h", bus_limit, ad);
      errors++;
    end
    rd = clic_rdata;
    model_write(ad, wd, st);
  endtask

  task automatic bus_write(input addr_t ad, input data_t wd, input strb_t st);
    data_t rd;
    int lat;
    bus_access(ad, wd, st, rd, lat);
  endtask

  task automatic read_check(input string test, input addr_t ad, output data_t rd);
    int lat;
    bus_access(ad, '0, '0, rd, lat);
    compare(test, expected_read(ad), rd);
  endtask

  task automatic pending_check(input string test, input int i, input logic exp);
    data_t rd;
    read_check(test, int_addr(i), rd);
    compare(test, {31'd0, exp}, {31'd0, rd[0]});
  endtask

  task automatic drive_lines(input int_vec_t next);
    for (int i = 0; i < clic_num_int; i++) begin
      if (sh_trig[i][0]) begin
        if (sh_trig[i][1] ? (lines_now[i] && !next[i]) : (!lines_now[i] && next[i])) begin
          sh_pending[i] = 1'b1;
        end
      end
    end
    lines_now = next;
    @(posedge clock);
    clic_irpt <= next;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  task automatic end_test(input string test);
    $display("%s: %0d checks, %0d errors", test, checks - first_check, errors - first_error);
    first_check = checks;
    first_error = errors;
  endtask

  initial begin
    reset = 1'b1;
    clic_valid = 1'b0;
    clic_addr = '0;
    clic_wdata = '0;
    clic_wstrb = '0;
    clic_irpt = '0;
    sh_enable = '0;
    sh_shv = '0;
    sh_pending = '0;
    sh_nlbits = '0;
    lines_now = '0;
    for (int i = 0; i < clic_num_int; i++) begin
      sh_trig[i] = '0;
      sh_mode[i] = '0;
      sh_ctl_hi[i] = 4'hf;
    end
    for (int i = 0; i < clic_num_trig; i++) sh_trig_word[i] = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    @(negedge clock);
    compare("reset_identity", 32'd0, {31'd0, clic_meip});
    read_check("reset_identity", 32'd4, r);
    read_check("reset_identity", 32'd0, r);
    for (int i = 0; i < clic_num_trig; i++) read_check("reset_identity", 32'(64 + 4 * i), r);
    read_check("reset_identity", int_addr(3), r);
    end_test("reset_identity");

    for (int n = 0; n < 80; n++) begin
      rnd = $random(seed);
      d = $random(seed);
      s = (rnd[23:20] == 4'd0) ? 4'h8 : rnd[23:20];
      case (rnd[5:4])
        2'd2: a = 32'(64 + 4 * int'(rnd[1:0]));
        2'd3: a = 32'd0;
        default: a = int_addr(int'(rnd[11:8]));
      endcase
      bus_write(a, d, s);
      read_check("register_access", a, r);
    end
    foreach (holes[k]) begin
      bus_write(holes[k], 32'hffff_ffff, 4'hf); // unmapped, must still answer.
      read_check("register_access", holes[k], r);
    end
    end_test("register_access");

    drive_lines('0);
    for (int k = 0; k < 2; k++) begin
      d = int_word(1'b0, 1'b1, 2'(2 * k), 4'h3); // trigger 0 and 2 are both level.
      bus_write(int_addr(5 + k), d, 4'hf);
      next_lines = '0;
      next_lines[5 + k] = 1'b1;
      drive_lines(next_lines);
      wait_cycles(2);
      pending_check("level_mode", 5 + k, 1'b1);
      bus_write(int_addr(5 + k), d, 4'h1);
      pending_check("level_mode", 5 + k, 1'b1);
      drive_lines('0);
      wait_cycles(2);
      pending_check("level_mode", 5 + k, 1'b0);
      bus_write(int_addr(5 + k), d | 32'd1, 4'h1);
      pending_check("level_mode", 5 + k, 1'b0);
    end
    end_test("level_mode");

    bus_write(int_addr(7), int_word(1'b0, 1'b1, 2'd1, 4'ha), 4'hf); // rising.
    bus_write(int_addr(9), int_word(1'b0, 1'b1, 2'd3, 4'h5), 4'hf); // falling.
    drive_lines(16'h0280);
    wait_cycles(2);
    pending_check("edge_mode", 7, 1'b1);
    pending_check("edge_mode", 9, 1'b0);
    drive_lines('0);
    wait_cycles(2);
    pending_check("edge_mode", 7, 1'b1);
    pending_check("edge_mode", 9, 1'b1);
    drive_lines(16'h0280);
    wait_cycles(2);
    bus_write(int_addr(7), 32'd0, 4'h1);
    bus_write(int_addr(9), 32'd0, 4'h1);
    pending_check("edge_mode", 7, 1'b0);
    pending_check("edge_mode", 9, 1'b0);
    drive_lines('0);
    wait_cycles(2);
    pending_check("edge_mode", 7, 1'b0);
    pending_check("edge_mode", 9, 1'b1);
    bus_write(int_addr(9), 32'd0, 4'h1);
    pending_check("edge_mode", 9, 1'b0);
    end_test("edge_mode");

    for (int n = 0; n < 200; n++) begin
      rnd = $random(seed);
      bus_write(32'd0, {27'd0, rnd[3:0], 1'b0}, 4'h1);
      for (int i = 0; i < clic_num_int; i++) begin
        d = $random(seed);
        // some rounds share one control byte so that ties occur.
        bus_write(int_addr(i), int_word(1'b0, d[8] || (n % 10 == 0), 2'd0,
                                        (n % 4 == 1) ? 4'h9 : d[31:28]), 4'hf);
      end
      d = $random(seed);
      drive_lines((n % 10 == 0) ? 16'h0001 : d[15:0]);
      wait_cycles(3);
      @(negedge clock);
      compare("arbitration_meid", data_t'(best_interrupt()), data_t'(clic_meid));
      compare("arbitration_meip", {31'd0, best_interrupt() != '0}, {31'd0, clic_meip});
    end
    end_test("arbitration");

    bus_access(32'd4, '0, '0, r, waited);
    compare("bus_timing", 32'd0, data_t'(waited));
    @(negedge clock);
    compare("bus_timing", 32'd0, {31'd0, clic_ready});
    @(posedge clock);
    clic_valid <= 1'b1;
    clic_addr <= burst[0];
    clic_wdata <= 32'ha5a5_5a5a;
    clic_wstrb <= burst_strb[0];
    for (int k = 1; k <= 5; k++) begin
      @(posedge clock);
      if (k < 5) begin
        clic_addr <= burst[k];
        clic_wstrb <= burst_strb[k];
      end else begin
        clic_valid <= 1'b0;
        clic_wstrb <= '0;
      end
      @(negedge clock);
      compare("bus_timing", 32'd1, {31'd0, clic_ready});
      if (burst_strb[k - 1] == 4'h0) begin
        compare("bus_timing", expected_read(burst[k - 1]), clic_rdata);
      end else begin
        model_write(burst[k - 1], 32'ha5a5_5a5a, burst_strb[k - 1]);
      end
    end
    @(negedge clock);
    compare("bus_timing", 32'd0, {31'd0, clic_ready});
    end_test("bus_timing");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
src/clic_pkg.sv
src/clic_regs.sv
src/clic_pending.sv
src/clic_arbiter.sv
src/clic_top.sv
bench/clic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module clic_tb -o clic_sim \
  && ./obj_dir/clic_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
! grep -q "TESTBENCH FAILED" sim.log
